//--- rtl/cpuPkg.sv
package cpuPkg;

	// data and address width of the machine
	localparam int WORD_WIDTH = 16;

	// every instruction is one 16-bit word, so sequential flow steps by two bytes
	localparam logic [WORD_WIDTH-1:0] PC_STEP = 16'd2;

	// interrupt entry addresses
	localparam logic [WORD_WIDTH-1:0] INT0_VECTOR = 16'h0008;
	localparam logic [WORD_WIDTH-1:0] INT1_VECTOR = 16'h0010;

	// instruction layout is group[15:14] skip[13:12] jump[11:8] cc[7:6] argA[5:3] argB[2:0]
	localparam logic [1:0] GROUP_JUMP = 2'b10;

	// condition modes held in the skip field
	localparam logic [1:0] SKIP_NONE   = 2'b00;
	localparam logic [1:0] SKIP_IF     = 2'b01;
	localparam logic [1:0] SKIP_IF_NOT = 2'b10;

	// jump kinds, any other code in the jump group means no jump
	localparam logic [3:0] JP_REL_S8  = 4'h1;
	localparam logic [3:0] JP_REL_U8H = 4'h2;
	localparam logic [3:0] JP_ABS_R   = 4'h3;
	localparam logic [3:0] JP_ABS_U8H = 4'h4;
	localparam logic [3:0] JP_RETI    = 4'h5;

	// condition flag select codes
	localparam logic [1:0] CC_Z = 2'd0;
	localparam logic [1:0] CC_C = 2'd1;
	localparam logic [1:0] CC_S = 2'd2;
	localparam logic [1:0] CC_P = 2'd3;

	// ALU B operand source reported to the datapath
	localparam logic [2:0] ALUB_REG_B = 3'd0;
	localparam logic [2:0] ALUB_S8    = 3'd1;
	localparam logic [2:0] ALUB_U8H   = 3'd2;

	// register file port B address source
	localparam logic [1:0] REGB_ARGB = 2'd0;
	localparam logic [1:0] REGB_RB   = 2'd1;

	// one-hot instruction phase levels
	typedef struct packed {
		logic fetch;
		logic decode;
		logic execute;
		logic commit;
	} phaseT;

	// condition codes from the ALU
	typedef struct packed {
		logic sign;
		logic carry;
		logic zero;
		logic parity;
	} ccFlagsT;

	// decoded jump group controls, all zero means no jump and default datapath routing
	typedef struct packed {
		logic       jr;
		logic       jmp;
		logic       ccApply;
		logic       ccInvert;
		logic       retI;
		logic [1:0] ccSelect;
		logic [1:0] regBAddr;
		logic [2:0] aluBSrc;
	} jumpCtrlT;

	// source of the next program counter value
	typedef enum logic [2:0] {
		PC_NEXT_INC,
		PC_NEXT_BRANCH,
		PC_NEXT_INT0,
		PC_NEXT_INT1,
		PC_NEXT_RETI
	} pcNextSelT;

endpackage

//--- rtl/instructionPhaseDecoder.sv
`timescale 1ns/1ps

module instructionPhaseDecoder (
	input  logic          CLK,
	input  logic          rstN,
	output cpuPkg::phaseT phase
);

	// next state of the ring, each phase hands its token to the following one
	cpuPkg::phaseT phaseNext;

	always_comb begin
		// commit wraps back to fetch so the ring never empties
		phaseNext.fetch   = phase.commit;
		phaseNext.decode  = phase.fetch;
		phaseNext.execute = phase.decode;
		phaseNext.commit  = phase.execute;
	end

	// the sequencer runs freely, one phase per clock and four clocks per instruction
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			// come out of reset at the start of an instruction
			phase.fetch   <= 1'b1;
			phase.decode  <= 1'b0;
			phase.execute <= 1'b0;
			phase.commit  <= 1'b0;
		end else begin
			phase <= phaseNext;
		end
	end

endmodule

//--- rtl/jumpGroupDecoder.sv
`timescale 1ns/1ps

module jumpGroupDecoder (
	input  logic             CLK,
	input  logic             rstN,
	input  logic [15:0]      instruction,
	input  cpuPkg::phaseT    phase,
	output cpuPkg::jumpCtrlT jumpCtrl
);

	// instruction fields used by the jump group
	logic [1:0] groupField;
	logic [1:0] skipField;
	logic [3:0] jumpField;
	logic [1:0] ccField;

	// controls decoded straight from the instruction bus during fetch
	cpuPkg::jumpCtrlT decoded;

	assign groupField = instruction[15:14];
	assign skipField  = instruction[13:12];
	assign jumpField  = instruction[11:8];
	assign ccField    = instruction[7:6];

	always_comb begin
		// the zero pattern is also ALUB_REG_B and REGB_ARGB, which is the quiet routing
		decoded = '0;
		if (groupField == cpuPkg::GROUP_JUMP) begin
			// condition handling applies to the whole group
			decoded.ccSelect = ccField;
			decoded.ccApply  = (skipField != cpuPkg::SKIP_NONE);
			decoded.ccInvert = (skipField == cpuPkg::SKIP_IF_NOT);
			decoded.aluBSrc  = cpuPkg::ALUB_REG_B;
			decoded.regBAddr = cpuPkg::REGB_ARGB;
			case (jumpField)
				cpuPkg::JP_REL_S8: begin
					// signed byte offset, the datapath sign-extends argA:argB
					decoded.jr      = 1'b1;
					decoded.jmp     = 1'b1;
					decoded.aluBSrc = cpuPkg::ALUB_S8;
				end
				cpuPkg::JP_REL_U8H: begin
					// byte goes in the high half over the low byte of RB
					decoded.jr       = 1'b1;
					decoded.jmp      = 1'b1;
					decoded.aluBSrc  = cpuPkg::ALUB_U8H;
					decoded.regBAddr = cpuPkg::REGB_RB;
				end
				cpuPkg::JP_ABS_R: begin
					// target is the register named by argB
					decoded.jmp = 1'b1;
				end
				cpuPkg::JP_ABS_U8H: begin
					decoded.jmp      = 1'b1;
					decoded.aluBSrc  = cpuPkg::ALUB_U8H;
					decoded.regBAddr = cpuPkg::REGB_RB;
				end
				cpuPkg::JP_RETI: begin
					// return is not a branch, the interrupt logic steers it
					decoded.retI = 1'b1;
				end
				default: begin
					// unused jump codes fall through as a plain step
					decoded.jmp = 1'b0;
				end
			endcase
		end
	end

	// capture on the edge that leaves fetch and hold through commit
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			jumpCtrl <= '0;
		end else if (phase.fetch) begin
			jumpCtrl <= decoded;
		end
	end

endmodule

//--- rtl/branchLogic.sv
`timescale 1ns/1ps

module branchLogic (
	input  cpuPkg::ccFlagsT  ccFlags,
	input  cpuPkg::jumpCtrlT jumpCtrl,
	output logic             taken,
	output logic             relative
);

	// flag picked by the cc field
	logic flag;

	// flag after the optional inversion for the not-skip mode
	logic conditionMet;

	always_comb begin
		flag = 1'b0;
		case (jumpCtrl.ccSelect)
			cpuPkg::CC_Z: flag = ccFlags.zero;
			cpuPkg::CC_C: flag = ccFlags.carry;
			cpuPkg::CC_S: flag = ccFlags.sign;
			cpuPkg::CC_P: flag = ccFlags.parity;
			default:      flag = 1'b0;
		endcase
	end

	assign conditionMet = flag ^ jumpCtrl.ccInvert;

	// an unconditional jump ignores the flags entirely
	assign taken = jumpCtrl.jmp & (~jumpCtrl.ccApply | conditionMet);

	// relative jumps add pcD to the current address, absolute ones load it
	assign relative = jumpCtrl.jr;

endmodule

//--- rtl/interruptStateMachine.sv
`timescale 1ns/1ps

module interruptStateMachine (
	input  logic               CLK,
	input  logic               rstN,
	input  cpuPkg::phaseT      phase,
	input  cpuPkg::jumpCtrlT   jumpCtrl,
	input  logic               taken,
	input  logic               ei,
	input  logic               di,
	input  logic               int0,
	input  logic               int1,
	output cpuPkg::pcNextSelT  pcNextSel,
	output logic               saveReturn
);

	// interrupts accepted when set, driven by ei, di and reti
	logic intEnable;

	// a handler is running and a nested entry is held off
	logic inService;

	// an interrupt is taken at this commit
	logic entry;

	assign entry = phase.commit & intEnable & ~inService & (int0 | int1);

	// a reti overtaken by an entry would have loaded the saved address itself,
	// so leaving that address in place is already the right return point
	assign saveReturn = entry & ~jumpCtrl.retI;

	always_comb begin
		// outside commit the selection is not used, keep it on the step path
		pcNextSel = cpuPkg::PC_NEXT_INC;
		if (phase.commit) begin
			if (entry) begin
				// int0 has the higher priority
				pcNextSel = int0 ? cpuPkg::PC_NEXT_INT0 : cpuPkg::PC_NEXT_INT1;
			end else if (jumpCtrl.retI) begin
				pcNextSel = cpuPkg::PC_NEXT_RETI;
			end else if (taken) begin
				pcNextSel = cpuPkg::PC_NEXT_BRANCH;
			end
		end
	end

	// state moves only at the end of commit
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			intEnable <= 1'b0;
			inService <= 1'b0;
		end else if (phase.commit) begin
			if (entry) begin
				// entering a handler masks further interrupts until reti
				inService <= 1'b1;
				intEnable <= 1'b0;
			end else if (jumpCtrl.retI) begin
				inService <= 1'b0;
				intEnable <= 1'b1;
			end else if (di) begin
				// di wins when both levels are high
				intEnable <= 1'b0;
			end else if (ei) begin
				intEnable <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/programCounter.sv
`timescale 1ns/1ps

module programCounter (
	input  logic                          CLK,
	input  logic                          rstN,
	input  cpuPkg::phaseT                 phase,
	input  cpuPkg::pcNextSelT             pcNextSel,
	input  logic                          relative,
	input  logic                          taken,
	input  logic                          saveReturn,
	input  logic [cpuPkg::WORD_WIDTH-1:0] pcD,
	output logic [cpuPkg::WORD_WIDTH-1:0] pcA
);

	// address of the following instruction
	logic [cpuPkg::WORD_WIDTH-1:0] incAddr;

	// jump target, relative to pcA or taken as is
	logic [cpuPkg::WORD_WIDTH-1:0] branchAddr;

	// where the program would go if no interrupt cut in
	logic [cpuPkg::WORD_WIDTH-1:0] returnAddr;

	// return point of the running handler
	logic [cpuPkg::WORD_WIDTH-1:0] savedAddr;

	logic [cpuPkg::WORD_WIDTH-1:0] nextAddr;

	assign incAddr    = pcA + cpuPkg::PC_STEP;
	assign branchAddr = relative ? (pcA + pcD) : pcD;
	assign returnAddr = taken ? branchAddr : incAddr;

	always_comb begin
		case (pcNextSel)
			cpuPkg::PC_NEXT_INC:    nextAddr = incAddr;
			cpuPkg::PC_NEXT_BRANCH: nextAddr = branchAddr;
			cpuPkg::PC_NEXT_INT0:   nextAddr = cpuPkg::INT0_VECTOR;
			cpuPkg::PC_NEXT_INT1:   nextAddr = cpuPkg::INT1_VECTOR;
			cpuPkg::PC_NEXT_RETI:   nextAddr = savedAddr;
			default:                nextAddr = incAddr;
		endcase
	end

	// pcA only moves on the edge that ends commit, so it is steady through fetch
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pcA       <= '0;
			savedAddr <= '0;
		end else if (phase.commit) begin
			pcA <= nextAddr;
			if (saveReturn) begin
				savedAddr <= returnAddr;
			end
		end
	end

endmodule

//--- rtl/jumpUnit.sv
`timescale 1ns/1ps

module jumpUnit (
	input  logic                          CLK,
	input  logic                          rstN,
	input  logic [15:0]                   instruction,
	input  logic [cpuPkg::WORD_WIDTH-1:0] pcD,
	input  cpuPkg::ccFlagsT               ccFlags,
	input  logic                          ei,
	input  logic                          di,
	input  logic                          int0,
	input  logic                          int1,
	output cpuPkg::phaseT                 phase,
	output cpuPkg::jumpCtrlT              jumpCtrl,
	output logic [cpuPkg::WORD_WIDTH-1:0] pcA
);

	// branch decision for the instruction in commit
	logic taken;
	logic relative;

	// next address source and interrupt entry strobe
	cpuPkg::pcNextSelT pcNextSel;
	logic              saveReturn;

	instructionPhaseDecoder phaseDecoder (
		.CLK   (CLK),
		.rstN  (rstN),
		.phase (phase)
	);

	// jumpCtrl also tells the datapath which operand and register port to use
	jumpGroupDecoder jumpDecoder (
		.CLK         (CLK),
		.rstN        (rstN),
		.instruction (instruction),
		.phase       (phase),
		.jumpCtrl    (jumpCtrl)
	);

	branchLogic branchLogicInst (
		.ccFlags  (ccFlags),
		.jumpCtrl (jumpCtrl),
		.taken    (taken),
		.relative (relative)
	);

	interruptStateMachine interruptStateMachineInst (
		.CLK        (CLK),
		.rstN       (rstN),
		.phase      (phase),
		.jumpCtrl   (jumpCtrl),
		.taken      (taken),
		.ei         (ei),
		.di         (di),
		.int0       (int0),
		.int1       (int1),
		.pcNextSel  (pcNextSel),
		.saveReturn (saveReturn)
	);

	programCounter counter (
		.CLK        (CLK),
		.rstN       (rstN),
		.phase      (phase),
		.pcNextSel  (pcNextSel),
		.relative   (relative),
		.taken      (taken),
		.saveReturn (saveReturn),
		.pcD        (pcD),
		.pcA        (pcA)
	);

endmodule

//--- dv/jumpUnitTb.sv
`timescale 1ns/1ps

module jumpUnitTb;

	localparam int NUM_INSTR = 400;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + 50;
	localparam logic [31:0] LFSR_SEED = 32'h9b66_4a61;
	// feedback taps of x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic                          CLK;
	logic                          rstN;
	logic [15:0]                   instruction;
	logic [cpuPkg::WORD_WIDTH-1:0] pcD;
	cpuPkg::ccFlagsT               ccFlags;
	logic                          ei;
	logic                          di;
	logic                          int0;
	logic                          int1;
	cpuPkg::phaseT                 phase;
	cpuPkg::jumpCtrlT              jumpCtrl;
	logic [cpuPkg::WORD_WIDTH-1:0] pcA;

	logic [31:0] lfsrState = LFSR_SEED;
	int          cycleCount = 0;

	// reference model state, updated once per commit
	logic [cpuPkg::WORD_WIDTH-1:0] modelPc;
	logic [cpuPkg::WORD_WIDTH-1:0] modelSaved;
	logic                          modelEnable;
	logic                          modelInService;

	// interrupt scenarios seen over the run
	int int0Entries = 0;
	int int1Entries = 0;
	int blockedDisabled = 0;
	int blockedInService = 0;
	int handlerReturns = 0;

	jumpUnit DUT (
		.CLK         (CLK),
		.rstN        (rstN),
		.instruction (instruction),
		.pcD         (pcD),
		.ccFlags     (ccFlags),
		.ei          (ei),
		.di          (di),
		.int0        (int0),
		.int1        (int1),
		.phase       (phase),
		.jumpCtrl    (jumpCtrl),
		.pcA         (pcA)
	);

	always #2 CLK = ~CLK;

	// a stuck sequencer or a lost edge ends here instead of running forever
	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			failRun("timeout, the instruction sequence did not finish in time");
		end
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// one Galois step, the bit shifted out is the random bit
	function automatic logic nextBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ LFSR_TAPS;
		end
		return outBit;
	endfunction

	function automatic logic [31:0] drawBits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], nextBit()};
		end
		return value;
	endfunction

	// phase level for step 0 to 3, built by field name
	function automatic cpuPkg::phaseT makePhase(input int step);
		cpuPkg::phaseT p;
		p = '0;
		case (step)
			0: p.fetch = 1'b1;
			1: p.decode = 1'b1;
			2: p.execute = 1'b1;
			default: p.commit = 1'b1;
		endcase
		return p;
	endfunction

	task automatic checkPhase(input cpuPkg::phaseT got, input cpuPkg::phaseT expected);
		if (got !== expected) begin
			failRun($sformatf("** Error: phase = 0x%h, expected 0x%h", got, expected));
		end
	endtask

	task automatic checkCtrl(input cpuPkg::jumpCtrlT got, input cpuPkg::jumpCtrlT expected);
		if (got !== expected) begin
			failRun($sformatf("** Error: jumpCtrl = 0x%h, expected 0x%h", got, expected));
		end
	endtask

	task automatic checkPc(input logic [cpuPkg::WORD_WIDTH-1:0] got,
			input logic [cpuPkg::WORD_WIDTH-1:0] expected);
		if (got !== expected) begin
			failRun($sformatf("** Error: pcA = 0x%h, expected 0x%h", got, expected));
		end
	endtask

	// expected controls straight from the instruction format rules
	function automatic cpuPkg::jumpCtrlT modelDecode(input logic [15:0] instr);
		cpuPkg::jumpCtrlT c;
		logic [3:0] kind;
		logic isU8h;
		c = '0;
		kind = instr[11:8];
		isU8h = (kind == cpuPkg::JP_REL_U8H) || (kind == cpuPkg::JP_ABS_U8H);
		if (instr[15:14] == cpuPkg::GROUP_JUMP) begin
			c.ccSelect = instr[7:6];
			c.ccApply = (instr[13:12] != cpuPkg::SKIP_NONE);
			c.ccInvert = (instr[13:12] == cpuPkg::SKIP_IF_NOT);
			c.jr = (kind == cpuPkg::JP_REL_S8) || (kind == cpuPkg::JP_REL_U8H);
			c.jmp = c.jr || (kind == cpuPkg::JP_ABS_R) || (kind == cpuPkg::JP_ABS_U8H);
			c.retI = (kind == cpuPkg::JP_RETI);
			c.regBAddr = isU8h ? cpuPkg::REGB_RB : cpuPkg::REGB_ARGB;
			if (kind == cpuPkg::JP_REL_S8) begin
				c.aluBSrc = cpuPkg::ALUB_S8;
			end else if (isU8h) begin
				c.aluBSrc = cpuPkg::ALUB_U8H;
			end else begin
				c.aluBSrc = cpuPkg::ALUB_REG_B;
			end
		end
		return c;
	endfunction

	// applies the next-address priority rules to the model at commit
	task automatic commitModel(input cpuPkg::jumpCtrlT ctrl);
		logic flag;
		logic taken;
		logic entry;
		logic [cpuPkg::WORD_WIDTH-1:0] otherwise;
		case (ctrl.ccSelect)
			cpuPkg::CC_Z: flag = ccFlags.zero;
			cpuPkg::CC_C: flag = ccFlags.carry;
			cpuPkg::CC_S: flag = ccFlags.sign;
			default: flag = ccFlags.parity;
		endcase
		taken = ctrl.jmp && (!ctrl.ccApply || (flag ^ ctrl.ccInvert));
		if (ctrl.retI) begin
			otherwise = modelSaved;
		end else if (taken) begin
			otherwise = ctrl.jr ? modelPc + pcD : pcD;
		end else begin
			otherwise = modelPc + cpuPkg::PC_STEP;
		end
		entry = modelEnable && !modelInService && (int0 || int1);
		if (entry) begin
			// the interrupted flow resumes where it would have gone
			modelSaved = otherwise;
			modelPc = int0 ? cpuPkg::INT0_VECTOR : cpuPkg::INT1_VECTOR;
			modelInService = 1'b1;
			modelEnable = 1'b0;
			if (int0) int0Entries++;
			else int1Entries++;
		end else begin
			// a request held off by a running handler or by a cleared enable
			if (int0 || int1) begin
				if (modelInService) begin
					blockedInService++;
				end else begin
					blockedDisabled++;
				end
			end
			modelPc = otherwise;
			if (ctrl.retI) begin
				if (modelInService) handlerReturns++;
				modelInService = 1'b0;
				modelEnable = 1'b1;
			end else if (di) begin
				modelEnable = 1'b0;
			end else if (ei) begin
				modelEnable = 1'b1;
			end
		end
	endtask

	// one instruction, entered and left on the falling edge in fetch
	task automatic runInstruction();
		logic [1:0] grp;
		logic [3:0] kind;
		cpuPkg::jumpCtrlT expCtrl;
		checkPhase(phase, makePhase(0));
		checkPc(pcA, modelPc);
		// three in four instructions belong to the jump group
		if (2'(drawBits(2)) != 2'b00) begin
			grp = cpuPkg::GROUP_JUMP;
		end else begin
			grp = 2'(drawBits(2));
			if (grp == cpuPkg::GROUP_JUMP) grp = 2'b11;
		end
		// kinds are biased toward the five defined codes
		case (3'(drawBits(3)))
			3'd0: kind = cpuPkg::JP_REL_S8;
			3'd1: kind = cpuPkg::JP_REL_U8H;
			3'd2: kind = cpuPkg::JP_ABS_R;
			3'd3: kind = cpuPkg::JP_ABS_U8H;
			3'd4: kind = cpuPkg::JP_RETI;
			default: kind = 4'(drawBits(4));
		endcase
		instruction = {grp, 2'(drawBits(2)), kind, 2'(drawBits(2)), 6'(drawBits(6))};
		pcD = 16'(drawBits(16));
		ccFlags = cpuPkg::ccFlagsT'(4'(drawBits(4)));
		ei = (2'(drawBits(2)) != 2'b00);
		di = (3'(drawBits(3)) == 3'b000);
		int0 = (3'(drawBits(3)) == 3'b000);
		int1 = (3'(drawBits(3)) == 3'b000);
		expCtrl = modelDecode(instruction);
		for (int step = 1; step < 4; step++) begin
			@(negedge CLK);
			checkPhase(phase, makePhase(step));
			checkCtrl(jumpCtrl, expCtrl);
			// pcA holds its value until the edge that ends commit
			checkPc(pcA, modelPc);
		end
		commitModel(expCtrl);
		@(negedge CLK);
	endtask

	initial begin
		CLK = 1'b0;
		rstN = 1'b0;
		instruction = '0;
		pcD = '0;
		ccFlags = '0;
		ei = 1'b0;
		di = 1'b0;
		int0 = 1'b0;
		int1 = 1'b0;
		modelPc = '0;
		modelSaved = '0;
		modelEnable = 1'b0;
		modelInService = 1'b0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1;
		// the reset state is fetch, pcA zero and no decoded jump
		checkCtrl(jumpCtrl, '0);
		for (int n = 0; n < NUM_INSTR; n++) begin
			runInstruction();
		end
		checkPhase(phase, makePhase(0));
		checkPc(pcA, modelPc);
		if (int0Entries > 0 && int1Entries > 0 && blockedDisabled > 0 &&
				blockedInService > 0 && handlerReturns > 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			failRun("not every interrupt entry, blocked request and return was exercised");
		end
	end

endmodule

//--- verilog.f
rtl/cpuPkg.sv
rtl/instructionPhaseDecoder.sv
rtl/jumpGroupDecoder.sv
rtl/branchLogic.sv
rtl/interruptStateMachine.sv
rtl/programCounter.sv
rtl/jumpUnit.sv
dv/jumpUnitTb.sv

//--- run.sh
#!/bin/sh
# builds the jump unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
	--top-module jumpUnitTb -o jumpUnitSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOutput=$(./obj_dir/jumpUnitSim)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

# the verdict comes from the pass line in the simulation output
if printf '%s\n' "$simOutput" | grep -q '^TEST PASSED$'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
